/* hdl/rv_exec_macros.svh */
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// Data path width, register count and register index width.
`define RV_XLEN   32
`define RV_NREGS  32
`define RV_REG_AW 5

`endif

/* hdl/rv_exec_pkg.sv */
`default_nettype none

`include "rv_exec_macros.svh"

package rv_exec_pkg;

   // Each covered instruction has its own value. OP_NONE comes last.
   typedef enum logic [5:0] {
      OP_ADDI,
      OP_SLTI,
      OP_SLTIU,
      OP_XORI,
      OP_ORI,
      OP_ANDI,
      OP_SLLI,
      OP_SRLI,
      OP_SRAI,
      OP_ADD,
      OP_SUB,
      OP_SLL,
      OP_SLT,
      OP_SLTU,
      OP_XOR,
      OP_SRL,
      OP_SRA,
      OP_OR,
      OP_AND,
      OP_BEQ,
      OP_BNE,
      OP_BLT,
      OP_BGE,
      OP_BLTU,
      OP_BGEU,
      OP_LB,
      OP_LH,
      OP_LW,
      OP_LBU,
      OP_LHU,
      OP_SB,
      OP_SH,
      OP_SW,
      OP_NONE
   } rv_op_e;

   typedef struct packed {
      rv_op_e                  op;
      logic [`RV_REG_AW-1:0]   rd;
      logic [`RV_REG_AW-1:0]   rs1;
      logic [`RV_REG_AW-1:0]   rs2;
      logic [`RV_XLEN-1:0]     imm;
   } dec_out_t;

   typedef struct packed {
      rv_op_e                  op;
      logic [`RV_REG_AW-1:0]   rd;
      logic [`RV_XLEN-1:0]     rs1_val;
      logic [`RV_XLEN-1:0]     rs2_val;
      logic [`RV_XLEN-1:0]     imm;
   } exec_req_t;

   typedef struct packed {
      logic                    en;
      logic [`RV_REG_AW-1:0]   rd;
      logic [`RV_XLEN-1:0]     data;
   } wb_t;

endpackage

`default_nettype wire

/* hdl/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_macros.svh"

module rv_decode
   import rv_exec_pkg::*;
(
   input  wire logic        inst_valid,
   input  wire logic [31:0] inst,
   output dec_out_t         dec
);

   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;

   logic [6:0]          opcode;
   logic [2:0]          funct3;
   logic [6:0]          funct7;
   logic [`RV_XLEN-1:0] imm_i;
   logic [`RV_XLEN-1:0] imm_s;
   rv_op_e              op;

   assign opcode = inst[6:0];
   assign funct3 = inst[14:12];
   assign funct7 = inst[31:25];

   assign imm_i = {{20{inst[31]}}, inst[31:20]};
   assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};

   always_comb begin
      op = OP_NONE;
      if (inst_valid) begin
         case (opcode)
            OPC_OP_IMM: begin
               case (funct3)
                  3'b000: op = OP_ADDI;
                  3'b010: op = OP_SLTI;
                  3'b011: op = OP_SLTIU;
                  3'b100: op = OP_XORI;
                  3'b110: op = OP_ORI;
                  3'b111: op = OP_ANDI;
                  3'b001: op = (funct7 == F7_BASE) ? OP_SLLI : OP_NONE;
                  3'b101: begin
                     if (funct7 == F7_BASE) begin
                        op = OP_SRLI;
                     end else if (funct7 == F7_ALT) begin
                        op = OP_SRAI;
                     end
                  end
                  default: op = OP_NONE;
               endcase
            end
            OPC_OP: begin
               if (funct7 == F7_BASE) begin
                  case (funct3)
                     3'b000: op = OP_ADD;
                     3'b001: op = OP_SLL;
                     3'b010: op = OP_SLT;
                     3'b011: op = OP_SLTU;
                     3'b100: op = OP_XOR;
                     3'b101: op = OP_SRL;
                     3'b110: op = OP_OR;
                     3'b111: op = OP_AND;
                     default: op = OP_NONE;
                  endcase
               end else if (funct7 == F7_ALT) begin
                  if (funct3 == 3'b000) begin
                     op = OP_SUB;
                  end else if (funct3 == 3'b101) begin
                     op = OP_SRA;
                  end
               end
            end
            OPC_BRANCH: begin
               case (funct3)
                  3'b000: op = OP_BEQ;
                  3'b001: op = OP_BNE;
                  3'b100: op = OP_BLT;
                  3'b101: op = OP_BGE;
                  3'b110: op = OP_BLTU;
                  3'b111: op = OP_BGEU;
                  default: op = OP_NONE;
               endcase
            end
            OPC_LOAD: begin
               case (funct3)
                  3'b000: op = OP_LB;
                  3'b001: op = OP_LH;
                  3'b010: op = OP_LW;
                  3'b100: op = OP_LBU;
                  3'b101: op = OP_LHU;
                  default: op = OP_NONE;
               endcase
            end
            OPC_STORE: begin
               case (funct3)
                  3'b000: op = OP_SB;
                  3'b001: op = OP_SH;
                  3'b010: op = OP_SW;
                  default: op = OP_NONE;
               endcase
            end
            default: op = OP_NONE;
         endcase
      end
   end

   // Only the fields the instruction format actually uses are passed on.
   always_comb begin
      dec    = '0;
      dec.op = op;
      if (op != OP_NONE) begin
         dec.rs1 = inst[19:15];
         case (opcode)
            OPC_OP_IMM: begin
               dec.rd = inst[11:7];
               if (op inside {OP_SLLI, OP_SRLI, OP_SRAI}) begin
                  dec.imm = {{(`RV_XLEN-5){1'b0}}, inst[24:20]};
               end else begin
                  dec.imm = imm_i;
               end
            end
            OPC_OP: begin
               dec.rd  = inst[11:7];
               dec.rs2 = inst[24:20];
            end
            OPC_LOAD: begin
               dec.rd  = inst[11:7];
               dec.imm = imm_i;
            end
            OPC_STORE: begin
               dec.rs2 = inst[24:20];
               dec.imm = imm_s;
            end
            OPC_BRANCH: dec.rs2 = inst[24:20];
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_macros.svh"

module rv_regfile
   import rv_exec_pkg::*;
(
   input  wire logic                  CLK,
   input  wire logic                  RST_N,
   input  wire logic [`RV_REG_AW-1:0] rs1,
   input  wire logic [`RV_REG_AW-1:0] rs2,
   output logic      [`RV_XLEN-1:0]   rs1_val,
   output logic      [`RV_XLEN-1:0]   rs2_val,
   input  wire wb_t                   wb
);

   // x0 has no storage.
   logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

   function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_AW-1:0] idx);
      logic [`RV_XLEN-1:0] val;
      if (idx == '0) begin
         val = '0;
      end else if (wb.en && wb.rd == idx) begin
         val = wb.data;
      end else begin
         val = regs[idx];
      end
      return val;
   endfunction

   always_ff @(posedge CLK) begin
      if (!RST_N) begin
         for (int i = 1; i < `RV_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.en && wb.rd != '0) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // A result in flight is forwarded so the next instruction sees it.
   always_comb begin
      rs1_val = read_port(rs1);
      rs2_val = read_port(rs2);
   end

   a_wb_not_x0: assert property (@(posedge CLK) disable iff (!RST_N)
      wb.en |-> wb.rd != '0)
      else $error("writeback enabled for x0");

endmodule

`default_nettype wire

/* hdl/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_macros.svh"

module rv_alu
   import rv_exec_pkg::*;
(
   input  wire logic                  CLK,
   input  wire logic                  RST_N,
   input  wire exec_req_t             req,
   output logic                       rslt_valid,
   output logic      [`RV_XLEN-1:0]   rslt,
   output logic      [`RV_REG_AW-1:0] rslt_rd,
   output wb_t                        wb
);

   logic                imm_sel;
   logic                is_branch;
   logic                is_store;
   logic [`RV_XLEN-1:0] op1;
   logic [`RV_XLEN-1:0] op2;
   logic [`RV_XLEN-1:0] add_sub;
   logic [`RV_XLEN-1:0] shl;
   logic [`RV_XLEN:0]   shr_ext;
   logic [`RV_XLEN-1:0] shr;
   logic                eq;
   logic                lts;
   logic                ltu;
   logic [`RV_XLEN-1:0] result;
   logic                valid_q;
   wb_t                 wb_q;

   function automatic logic [`RV_XLEN-1:0] flag(input logic bit_in);
      return {{(`RV_XLEN-1){1'b0}}, bit_in};
   endfunction

   always_comb begin
      imm_sel   = 1'b0;
      is_branch = 1'b0;
      is_store  = 1'b0;
      case (req.op)
         OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
         OP_SLLI, OP_SRLI, OP_SRAI,
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: imm_sel = 1'b1;
         OP_SB, OP_SH, OP_SW: begin
            imm_sel  = 1'b1;
            is_store = 1'b1;
         end
         OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: is_branch = 1'b1;
         default: ;
      endcase
   end

   assign op1 = req.rs1_val;
   assign op2 = imm_sel ? req.imm : req.rs2_val;

   assign add_sub = (req.op == OP_SUB) ? op1 - op2 : op1 + op2;
   assign shl     = op1 << op2[4:0];

   // The extra top bit carries the sign for arithmetic shifts and stays zero for logical ones.
   assign shr_ext = $signed({(req.op == OP_SRA || req.op == OP_SRAI) ? op1[`RV_XLEN-1] : 1'b0,
                             op1}) >>> op2[4:0];
   assign shr     = shr_ext[`RV_XLEN-1:0];

   assign eq  = op1 == op2;
   assign lts = $signed(op1) < $signed(op2);
   assign ltu = op1 < op2;

   always_comb begin
      case (req.op)
         OP_ADDI, OP_ADD, OP_SUB,
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
         OP_SB, OP_SH, OP_SW:              result = add_sub;
         OP_SLTI, OP_SLT, OP_BLT:          result = flag(lts);
         OP_SLTIU, OP_SLTU, OP_BLTU:       result = flag(ltu);
         OP_SLLI, OP_SLL:                  result = shl;
         OP_SRLI, OP_SRAI, OP_SRL, OP_SRA: result = shr;
         OP_XORI, OP_XOR:                  result = op1 ^ op2;
         OP_ORI, OP_OR:                    result = op1 | op2;
         OP_ANDI, OP_AND:                  result = op1 & op2;
         OP_BEQ:                           result = flag(eq);
         OP_BNE:                           result = flag(!eq);
         OP_BGE:                           result = flag(!lts);
         OP_BGEU:                          result = flag(!ltu);
         default:                          result = '0;
      endcase
   end

   always_ff @(posedge CLK) begin
      if (!RST_N) begin
         valid_q <= 1'b0;
         wb_q    <= '0;
      end else begin
         valid_q   <= req.op != OP_NONE;
         // Branches and stores leave the register file alone.
         wb_q.en   <= req.op != OP_NONE && !is_branch && !is_store && req.rd != '0;
         wb_q.rd   <= req.rd;
         wb_q.data <= result;
      end
   end

   assign rslt_valid = valid_q;
   assign rslt       = wb_q.data;
   assign rslt_rd    = wb_q.rd;
   assign wb         = wb_q;

   // The decoder clears rd for formats without one, so rslt_rd reads zero for them.
   a_no_rd_without_wb: assert property (@(posedge CLK) disable iff (!RST_N)
      (is_branch || is_store) |-> req.rd == '0)
      else $error("branch or store request carries a destination register");

endmodule

`default_nettype wire

/* hdl/rv_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_macros.svh"

module rv_exec_top
   import rv_exec_pkg::*;
(
   input  wire logic                  CLK,
   input  wire logic                  RST_N,
   input  wire logic                  inst_valid,
   input  wire logic [31:0]           inst,
   output logic                       rslt_valid,
   output logic      [`RV_XLEN-1:0]   rslt,
   output logic      [`RV_REG_AW-1:0] rslt_rd
);

   dec_out_t            dec;
   exec_req_t           req;
   wb_t                 wb;
   logic [`RV_XLEN-1:0] rs1_val;
   logic [`RV_XLEN-1:0] rs2_val;

   rv_decode u_decode (
      .inst_valid (inst_valid),
      .inst       (inst),
      .dec        (dec)
   );

   rv_regfile u_regfile (
      .CLK     (CLK),
      .RST_N   (RST_N),
      .rs1     (dec.rs1),
      .rs2     (dec.rs2),
      .rs1_val (rs1_val),
      .rs2_val (rs2_val),
      .wb      (wb)
   );

   // Decoded fields and operand values form the ALU request.
   assign req.op      = dec.op;
   assign req.rd      = dec.rd;
   assign req.rs1_val = rs1_val;
   assign req.rs2_val = rs2_val;
   assign req.imm     = dec.imm;

   rv_alu u_alu (
      .CLK        (CLK),
      .RST_N      (RST_N),
      .req        (req),
      .rslt_valid (rslt_valid),
      .rslt       (rslt),
      .rslt_rd    (rslt_rd),
      .wb         (wb)
   );

endmodule

`default_nettype wire

/* test/tb_rv_exec_model.svh */
`ifndef TB_RV_EXEC_MODEL_SVH
`define TB_RV_EXEC_MODEL_SVH

typedef struct packed {
   logic        valid;
   logic [4:0]  rd;
   logic [31:0] data;
} exp_t;

// Register state in program order. Entry 0 is never written.
logic [31:0] shadow [0:31] = '{default: 32'h0};

function automatic logic [31:0] lcg(input logic [31:0] s);
   return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [31:0] shift_right(input logic [31:0] x, input logic [4:0] n,
                                            input logic arith);
   if (arith) begin
      return $signed(x) >>> n;
   end
   return x >> n;
endfunction

// Executes one word as the ISA defines it and updates the shadow registers.
task automatic predict(input logic v, input logic [31:0] w, output exp_t e);
   logic [2:0]  f3;
   logic [6:0]  f7;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] ii;
   logic        ok;
   logic        wr;
   f3 = w[14:12];
   f7 = w[31:25];
   a  = shadow[w[19:15]];
   ii = {{20{w[31]}}, w[31:20]};
   b  = (w[6:0] == 7'h13) ? ii : shadow[w[24:20]];
   ok = 1'b0;
   wr = 1'b0;
   e  = '0;
   case (w[6:0])
      7'h13, 7'h33: begin
         wr = 1'b1;
         if (w[5]) begin
            ok = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
         end else begin
            ok = (f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20);
         end
         case (f3)
            3'd0: e.data = (w[5] && f7[5]) ? a - b : a + b;
            3'd1: e.data = a << b[4:0];
            3'd2: e.data = {31'b0, $signed(a) < $signed(b)};
            3'd3: e.data = {31'b0, a < b};
            3'd4: e.data = a ^ b;
            3'd5: e.data = shift_right(a, b[4:0], f7[5]);
            3'd6: e.data = a | b;
            default: e.data = a & b;
         endcase
      end
      7'h63: begin
         ok = f3 != 3'd2 && f3 != 3'd3;
         case (f3)
            3'd0: e.data = {31'b0, a == b};
            3'd1: e.data = {31'b0, a != b};
            3'd4: e.data = {31'b0, $signed(a) < $signed(b)};
            3'd5: e.data = {31'b0, $signed(a) >= $signed(b)};
            3'd6: e.data = {31'b0, a < b};
            default: e.data = {31'b0, a >= b};
         endcase
      end
      7'h03: begin
         wr     = 1'b1;
         ok     = f3 != 3'd3 && f3 <= 3'd5;
         e.data = a + ii;
      end
      7'h23: begin
         ok     = f3 <= 3'd2;
         e.data = a + {ii[31:5], w[11:7]};
      end
      default: ;
   endcase
   e.valid = ok && v;
   e.rd    = wr ? w[11:7] : 5'd0;
   if (e.valid && wr && e.rd != 5'd0) begin
      shadow[e.rd] = e.data;
   end
endtask

`endif

/* test/tb_rv_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec;

   localparam int RESET_CYCLES = 16;
   localparam int N_DIRECTED   = 40;
   localparam int N_RANDOM     = 400;
   localparam int MAX_CYCLES   = RESET_CYCLES + N_DIRECTED + N_RANDOM + 64;

   logic        CLK        = 1'b0;
   logic        RST_N      = 1'b0;
   logic        inst_valid = 1'b0;
   logic [31:0] inst       = '0;
   logic        rslt_valid;
   logic [31:0] rslt;
   logic [4:0]  rslt_rd;
   logic        quiet      = 1'b0;
   logic [31:0] seed       = 32'h96d5a503;
   int          errors     = 0;
   int          cycles     = 0;

   `include "tb_rv_exec_model.svh"

   exp_t exp_cur = '0;
   exp_t exp_q   = '0;

   rv_exec_top u_dut (
      .CLK        (CLK),
      .RST_N      (RST_N),
      .inst_valid (inst_valid),
      .inst       (inst),
      .rslt_valid (rslt_valid),
      .rslt       (rslt),
      .rslt_rd    (rslt_rd)
   );

   initial begin
      forever #2 CLK = ~CLK;
   end

   // Fields in encoding order. I and S immediates span f7 with rs2 or rd.
   function automatic logic [31:0] word(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
      return {f7, rs2, rs1, f3, rd, opc};
   endfunction

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, want);
   endtask

   task automatic issue(input logic v, input logic [31:0] w);
      exp_t e;
      @(posedge CLK);
      inst_valid <= v;
      inst       <= w;
      predict(v, w, e);
      exp_cur    <= e;
   endtask

   // Mostly covered encodings on x0 to x7, with raw immediates and funct7 mixed in.
   task automatic issue_random();
      logic [31:0] r;
      logic [6:0]  opc;
      seed = lcg(seed);
      r    = seed ^ (seed >> 15);
      case (r[11:9])
         3'd0, 3'd1: opc = 7'h13;
         3'd2, 3'd3: opc = 7'h33;
         3'd4:       opc = 7'h63;
         3'd5:       opc = 7'h03;
         3'd6:       opc = 7'h23;
         default:    opc = r[6:0];
      endcase
      issue(r[31:28] != 4'h0,
            word(r[16] ? r[23:17] : {1'b0, r[15], 5'b0}, r[16] ? r[28:24] : {2'b0, r[8:6]},
                 {2'b0, r[5:3]}, r[14:12], {2'b0, r[2:0]}, opc));
   endtask

   // The expected register lines up with the registered DUT outputs.
   always @(posedge CLK) begin
      exp_q  <= exp_cur;
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   a_valid: assert property (@(posedge CLK) disable iff (!RST_N) rslt_valid == exp_q.valid)
      else report_value("rslt_valid", 32'($sampled(rslt_valid)), 32'($sampled(exp_q.valid)));
   a_data: assert property (@(posedge CLK) disable iff (!RST_N)
      exp_q.valid |-> rslt == exp_q.data)
      else report_value("rslt", $sampled(rslt), $sampled(exp_q.data));
   a_rd: assert property (@(posedge CLK) disable iff (!RST_N)
      exp_q.valid |-> rslt_rd == exp_q.rd)
      else report_value("rslt_rd", 32'($sampled(rslt_rd)), 32'($sampled(exp_q.rd)));
   a_quiet_valid: assert property (@(posedge CLK) quiet |-> !rslt_valid)
      else report_value("rslt_valid", 32'($sampled(rslt_valid)), 32'h0);
   a_quiet_rslt: assert property (@(posedge CLK) quiet |-> rslt == '0)
      else report_value("rslt", $sampled(rslt), 32'h0);

   initial begin
      @(posedge CLK);
      quiet <= 1'b1;
      repeat (RESET_CYCLES - 1) @(posedge CLK);
      RST_N <= 1'b1;
      repeat (3) @(posedge CLK);
      quiet <= 1'b0;

      // x1 = -5 and x2 = 100.
      issue(1'b1, word(7'h7f, 5'h1b, 5'd0, 3'd0, 5'd1, 7'h13));
      issue(1'b1, word(7'h03, 5'h04, 5'd0, 3'd0, 5'd2, 7'h13));
      for (int f = 0; f < 8; f++) begin
         issue(1'b1, word((f == 1 || f == 5) ? 7'h00 : 7'h7c, f[4:0] + 5'd3, 5'd1, f[2:0],
                          {3'b001, f[1:0]}, 7'h13));
      end
      issue(1'b1, word(7'h20, 5'd2, 5'd1, 3'd5, 5'd7, 7'h13));

      // Each register op reads the rd of the one before it.
      for (int f = 0; f < 8; f++) begin
         issue(1'b1, word(7'h00, 5'd2, {3'b001, f[1:0] - 2'd1}, f[2:0], {3'b001, f[1:0]},
                          7'h33));
      end
      issue(1'b1, word(7'h20, 5'd1, 5'd4, 3'd0, 5'd5, 7'h33));
      issue(1'b1, word(7'h20, 5'd5, 5'd1, 3'd5, 5'd6, 7'h33));
      issue(1'b1, word(7'h00, 5'd2, 5'd1, 3'd0, 5'd0, 7'h33));
      issue(1'b1, word(7'h00, 5'd0, 5'd0, 3'd0, 5'd3, 7'h33));

      for (int f = 0; f < 8; f++) begin
         if (f != 2 && f != 3) begin
            issue(1'b1, word(7'h00, 5'd2, 5'd1, f[2:0], 5'd0, 7'h63));
         end
      end
      for (int f = 0; f < 6; f++) begin
         if (f != 3) begin
            issue(1'b1, word(7'h7f, 5'h1c, {3'b001, f[1:0] - 2'd1}, f[2:0],
                             {3'b001, f[1:0]}, 7'h03));
         end
      end
      for (int f = 0; f < 3; f++) begin
         issue(1'b1, word(7'h40, {3'b001, f[1:0]}, 5'd1, f[2:0], 5'h15, 7'h23));
      end

      // Idle strobe, LUI, and SLLI with a bad funct7.
      issue(1'b0, word(7'h00, 5'd1, 5'd0, 3'd0, 5'd1, 7'h13));
      issue(1'b1, 32'h123450b7);
      issue(1'b1, word(7'h20, 5'd3, 5'd2, 3'd1, 5'd2, 7'h13));

      for (int n = 0; n < N_RANDOM; n++) begin
         issue_random();
      end
      issue(1'b0, 32'h0);
      repeat (3) @(posedge CLK);

      $display("checks done with %0d errors", errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
+incdir+hdl
+incdir+test
hdl/rv_exec_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_exec_top.sv
test/tb_rv_exec.sv

/* Bender.yml */
package:
  name: rv_exec

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_exec_pkg.sv
      - hdl/rv_decode.sv
      - hdl/rv_regfile.sv
      - hdl/rv_alu.sv
      - hdl/rv_exec_top.sv
  - target: test
    include_dirs:
      - hdl
      - test
    files:
      - test/tb_rv_exec.sv
